/* rtl/yolo_pkg.sv */
`default_nettype none

package yolo_pkg;

    // feature map geometry
    localparam int GRID_COLS = 15;
    localparam int GRID_ROWS = 10;

    // interior window with inclusive bounds
    localparam int WIN_COL_LO = 1;
    localparam int WIN_COL_HI = 12;
    localparam int WIN_ROW_LO = 1;
    localparam int WIN_ROW_HI = 7;

    // ranking depth
    localparam int KEEP_N = 5;

    // confidence byte sits above the packed box
    localparam int CONF_LSB = 32;

    // box word and info word per rank
    localparam int RESULT_WORDS = 2 * KEEP_N;

    typedef logic [63:0] beat_t;
    typedef logic [7:0]  conf_t;
    typedef logic [31:0] box_t;
    typedef logic [3:0]  col_t;
    typedef logic [3:0]  row_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  rd_addr_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_RUN,
        SCAN_DONE
    } scan_state_t;

endpackage

`default_nettype wire

/* rtl/grid_scanner.sv */
`timescale 1ns/1ns
`default_nettype none

module grid_scanner (
    input  logic           clk,
    input  logic           e203_rst_n,
    input  logic           i_start,
    input  logic           i_clr,
    input  logic           i_valid,
    output logic           o_ready,
    output logic           o_beat_fire,
    output logic           o_in_window,
    output yolo_pkg::col_t o_col,
    output yolo_pkg::row_t o_row,
    output logic           o_frame_last,
    output logic           o_frame_open
);
    import yolo_pkg::*;

    scan_state_t state_q;
    col_t        col_q;
    row_t        row_q;
    logic        col_wrap;
    logic        row_last;

    assign o_ready      = (state_q == SCAN_RUN);
    assign o_frame_open = (state_q == SCAN_IDLE) && i_start;
    assign o_beat_fire  = i_valid && o_ready;

    assign col_wrap     = (col_q == col_t'(GRID_COLS - 1));
    assign row_last     = (row_q == row_t'(GRID_ROWS - 1));
    assign o_frame_last = o_beat_fire && col_wrap && row_last;

    // interior cells only
    assign o_in_window = (col_q >= col_t'(WIN_COL_LO)) && (col_q <= col_t'(WIN_COL_HI)) &&
                         (row_q >= row_t'(WIN_ROW_LO)) && (row_q <= row_t'(WIN_ROW_HI));

    assign o_col = col_q;
    assign o_row = row_q;

    always_ff @(posedge clk or negedge e203_rst_n) begin
        if (!e203_rst_n) begin
            state_q <= SCAN_IDLE;
        end else begin
            case (state_q)
                SCAN_IDLE: if (i_start) state_q <= SCAN_RUN;
                SCAN_RUN:  if (o_frame_last) state_q <= SCAN_DONE;
                SCAN_DONE: if (i_clr) state_q <= SCAN_IDLE;
                default:   state_q <= SCAN_IDLE;
            endcase
        end
    end

    // column runs fastest
    always_ff @(posedge clk or negedge e203_rst_n) begin
        if (!e203_rst_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (o_frame_open) begin
            col_q <= '0;
            row_q <= '0;
        end else if (o_beat_fire) begin
            if (col_wrap) begin
                col_q <= '0;
                row_q <= row_last ? row_t'(0) : row_q + row_t'(1);
            end else begin
                col_q <= col_q + col_t'(1);
            end
        end
    end

    col_range_a : assert property (@(posedge clk) disable iff (!e203_rst_n)
        col_q <= col_t'(GRID_COLS - 1));

endmodule

`default_nettype wire

/* rtl/top5_sorter.sv */
`timescale 1ns/1ns
`default_nettype none

module top5_sorter (
    input  logic            clk,
    input  logic            e203_rst_n,
    input  logic            i_frame_open,
    input  logic            i_beat_fire,
    input  logic            i_in_window,
    input  logic            i_frame_last,
    input  yolo_pkg::beat_t i_beat,
    input  yolo_pkg::col_t  i_col,
    input  yolo_pkg::row_t  i_row,
    output yolo_pkg::conf_t o_conf [yolo_pkg::KEEP_N],
    output yolo_pkg::box_t  o_box  [yolo_pkg::KEEP_N],
    output yolo_pkg::col_t  o_col  [yolo_pkg::KEEP_N],
    output yolo_pkg::row_t  o_row  [yolo_pkg::KEEP_N],
    output logic            o_rank_valid
);
    import yolo_pkg::*;

    conf_t cur_conf;
    box_t  cur_box;

    conf_t conf_q [KEEP_N];
    box_t  box_q  [KEEP_N];
    col_t  col_q  [KEEP_N];
    row_t  row_q  [KEEP_N];

    conf_t nxt_conf [KEEP_N];
    box_t  nxt_box  [KEEP_N];
    col_t  nxt_col  [KEEP_N];
    row_t  nxt_row  [KEEP_N];

    logic [KEEP_N-1:0] gt;
    logic              take;

    assign cur_conf = i_beat[CONF_LSB +: $bits(conf_t)];
    assign cur_box  = i_beat[$bits(box_t)-1:0];
    assign take     = i_beat_fire && i_in_window;

    // strict compare, so a tie keeps the earlier cell ahead
    always_comb begin
        for (int k = 0; k < KEEP_N; k++) begin
            gt[k] = cur_conf > conf_q[k];
        end
    end

    // gt is a thermometer since ranks never increase
    always_comb begin
        nxt_conf[0] = gt[0] ? cur_conf : conf_q[0];
        nxt_box[0]  = gt[0] ? cur_box  : box_q[0];
        nxt_col[0]  = gt[0] ? i_col    : col_q[0];
        nxt_row[0]  = gt[0] ? i_row    : row_q[0];
        for (int k = 1; k < KEEP_N; k++) begin
            if (gt[k-1]) begin
                nxt_conf[k] = conf_q[k-1];
                nxt_box[k]  = box_q[k-1];
                nxt_col[k]  = col_q[k-1];
                nxt_row[k]  = row_q[k-1];
            end else if (gt[k]) begin
                nxt_conf[k] = cur_conf;
                nxt_box[k]  = cur_box;
                nxt_col[k]  = i_col;
                nxt_row[k]  = i_row;
            end else begin
                nxt_conf[k] = conf_q[k];
                nxt_box[k]  = box_q[k];
                nxt_col[k]  = col_q[k];
                nxt_row[k]  = row_q[k];
            end
        end
    end

    always_ff @(posedge clk or negedge e203_rst_n) begin
        if (!e203_rst_n) begin
            for (int k = 0; k < KEEP_N; k++) begin
                conf_q[k] <= '0;
            end
        end else if (i_frame_open) begin
            for (int k = 0; k < KEEP_N; k++) begin
                conf_q[k] <= '0;
            end
        end else if (take) begin
            conf_q <= nxt_conf;
        end
    end

    // empty ranks read back as zero
    always_ff @(posedge clk) begin
        if (i_frame_open) begin
            for (int k = 0; k < KEEP_N; k++) begin
                box_q[k] <= '0;
                col_q[k] <= '0;
                row_q[k] <= '0;
            end
        end else if (take) begin
            box_q <= nxt_box;
            col_q <= nxt_col;
            row_q <= nxt_row;
        end
    end

    always_ff @(posedge clk or negedge e203_rst_n) begin
        if (!e203_rst_n) begin
            o_rank_valid <= 1'b0;
        end else begin
            o_rank_valid <= i_frame_last;
        end
    end

    assign o_conf = conf_q;
    assign o_box  = box_q;
    assign o_col  = col_q;
    assign o_row  = row_q;

    for (genvar k = 1; k < KEEP_N; k++) begin : g_order_chk
        conf_order_a : assert property (@(posedge clk) disable iff (!e203_rst_n)
            conf_q[k-1] >= conf_q[k]);
    end

endmodule

`default_nettype wire

/* rtl/result_store.sv */
`timescale 1ns/1ns
`default_nettype none

module result_store (
    input  logic               clk,
    input  logic               e203_rst_n,
    input  logic               i_rank_valid,
    input  logic               i_clr,
    input  yolo_pkg::conf_t    i_conf [yolo_pkg::KEEP_N],
    input  yolo_pkg::box_t     i_box  [yolo_pkg::KEEP_N],
    input  yolo_pkg::col_t     i_col  [yolo_pkg::KEEP_N],
    input  yolo_pkg::row_t     i_row  [yolo_pkg::KEEP_N],
    input  yolo_pkg::rd_addr_t i_rd_addr,
    output yolo_pkg::word_t    o_rd_data,
    output logic               o_done
);
    import yolo_pkg::*;

    word_t words_q [RESULT_WORDS];
    word_t rd_q;
    logic  done_q;
    logic  addr_ok;

    assign addr_ok = (i_rd_addr < rd_addr_t'(RESULT_WORDS));

    // even word is the box, odd word packs conf, col and row
    always_ff @(posedge clk or negedge e203_rst_n) begin
        if (!e203_rst_n) begin
            for (int w = 0; w < RESULT_WORDS; w++) begin
                words_q[w] <= '0;
            end
        end else if (i_rank_valid) begin
            for (int k = 0; k < KEEP_N; k++) begin
                words_q[2*k]   <= word_t'(i_box[k]);
                words_q[2*k+1] <= {i_conf[k], i_col[k], i_row[k], 16'h0000};
            end
        end
    end

    // held until the host clears it
    always_ff @(posedge clk or negedge e203_rst_n) begin
        if (!e203_rst_n) begin
            done_q <= 1'b0;
        end else if (i_clr) begin
            done_q <= 1'b0;
        end else if (i_rank_valid) begin
            done_q <= 1'b1;
        end
    end

    // unmapped addresses read back as zero one cycle later
    always_ff @(posedge clk or negedge e203_rst_n) begin
        if (!e203_rst_n) begin
            rd_q <= '0;
        end else if (addr_ok) begin
            rd_q <= words_q[i_rd_addr];
        end else begin
            rd_q <= '0;
        end
    end

    assign o_rd_data = rd_q;
    assign o_done    = done_q;

    done_cause_a : assert property (@(posedge clk) disable iff (!e203_rst_n)
        $rose(done_q) |-> $past(i_rank_valid));

endmodule

`default_nettype wire

/* rtl/yolo_layer_top.sv */
`timescale 1ns/1ns
`default_nettype none

module yolo_layer_top (
    input  logic               clk,
    input  logic               e203_rst_n,
    input  logic               i_start,
    input  logic               i_clr,
    input  logic               i_valid,
    input  yolo_pkg::beat_t    i_beat,
    input  yolo_pkg::rd_addr_t i_rd_addr,
    output logic               o_ready,
    output yolo_pkg::word_t    o_rd_data,
    output logic               o_done
);
    import yolo_pkg::*;

    wire       beat_fire;
    wire       in_window;
    wire col_t cur_col;
    wire row_t cur_row;
    wire       frame_last;
    wire       frame_open;

    wire conf_t rank_conf [KEEP_N];
    wire box_t  rank_box  [KEEP_N];
    wire col_t  rank_col  [KEEP_N];
    wire row_t  rank_row  [KEEP_N];
    wire        rank_valid;

    grid_scanner u_grid_scanner (
        .clk          (clk),
        .e203_rst_n   (e203_rst_n),
        .i_start      (i_start),
        .i_clr        (i_clr),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .o_beat_fire  (beat_fire),
        .o_in_window  (in_window),
        .o_col        (cur_col),
        .o_row        (cur_row),
        .o_frame_last (frame_last),
        .o_frame_open (frame_open)
    );

    top5_sorter u_top5_sorter (
        .clk          (clk),
        .e203_rst_n   (e203_rst_n),
        .i_frame_open (frame_open),
        .i_beat_fire  (beat_fire),
        .i_in_window  (in_window),
        .i_frame_last (frame_last),
        .i_beat       (i_beat),
        .i_col        (cur_col),
        .i_row        (cur_row),
        .o_conf       (rank_conf),
        .o_box        (rank_box),
        .o_col        (rank_col),
        .o_row        (rank_row),
        .o_rank_valid (rank_valid)
    );

    result_store u_result_store (
        .clk          (clk),
        .e203_rst_n   (e203_rst_n),
        .i_rank_valid (rank_valid),
        .i_clr        (i_clr),
        .i_conf       (rank_conf),
        .i_box        (rank_box),
        .i_col        (rank_col),
        .i_row        (rank_row),
        .i_rd_addr    (i_rd_addr),
        .o_rd_data    (o_rd_data),
        .o_done       (o_done)
    );

endmodule

`default_nettype wire

/* test/tb_yolo_layer.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_yolo_layer;
    import yolo_pkg::*;

    localparam int NUM_BEATS   = GRID_COLS * GRID_ROWS;
    localparam int NUM_TESTS   = 6;
    localparam int WATCHDOG_NS = NUM_TESTS * (2 * NUM_BEATS + 60) * 20;
    localparam int MODE_BORDER = 1;
    localparam int MODE_EQUAL  = 2;
    localparam int MODE_SPARSE = 3;

    // {confidence mode, gap enable, start-while-busy probe}
    localparam logic [3:0] CASE_TAB [NUM_TESTS] = '{
        4'b00_0_0, 4'b00_1_1, 4'b01_0_0, 4'b10_1_0, 4'b11_0_1, 4'b01_1_1
    };

    logic     clk;
    logic     e203_rst_n;
    logic     i_start;
    logic     i_clr;
    logic     i_valid;
    beat_t    i_beat;
    rd_addr_t i_rd_addr;
    logic     o_ready;
    word_t    o_rd_data;
    logic     o_done;

    beat_t       beat_mem [NUM_BEATS];
    conf_t       exp_conf [KEEP_N];
    box_t        exp_box  [KEEP_N];
    col_t        exp_col  [KEEP_N];
    row_t        exp_row  [KEEP_N];
    logic [31:0] rng;
    int          errors;
    int          test_errs;
    int          failed_tests;

    yolo_layer_top dut_i (
        .clk        (clk),
        .e203_rst_n (e203_rst_n),
        .i_start    (i_start),
        .i_clr      (i_clr),
        .i_valid    (i_valid),
        .i_beat     (i_beat),
        .i_rd_addr  (i_rd_addr),
        .o_ready    (o_ready),
        .o_rd_data  (o_rd_data),
        .o_done     (o_done)
    );

    always #10 clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not complete within the expected time");
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] rand32();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
            errors++;
            test_errs++;
        end
    endtask

    // reference ranking where only a strictly greater confidence takes a rank
    task automatic rank_insert(input conf_t c, input box_t b, input col_t cl, input row_t rw);
        int pos;
        pos = KEEP_N;
        for (int k = 0; k < KEEP_N; k++) begin
            if (pos == KEEP_N && c > exp_conf[k]) pos = k;
        end
        for (int k = KEEP_N - 1; k > pos; k--) begin
            exp_conf[k] = exp_conf[k-1];
            exp_box[k]  = exp_box[k-1];
            exp_col[k]  = exp_col[k-1];
            exp_row[k]  = exp_row[k-1];
        end
        if (pos < KEEP_N) begin
            exp_conf[pos] = c;
            exp_box[pos]  = b;
            exp_col[pos]  = cl;
            exp_row[pos]  = rw;
        end
    endtask

    task automatic build_frame(input int mode);
        int          col;
        int          row;
        logic        in_win;
        logic [31:0] r;
        box_t        box;
        conf_t       conf;
        for (int k = 0; k < KEEP_N; k++) begin
            exp_conf[k] = '0;
            exp_box[k]  = '0;
            exp_col[k]  = '0;
            exp_row[k]  = '0;
        end
        for (int i = 0; i < NUM_BEATS; i++) begin
            col    = i % GRID_COLS;
            row    = i / GRID_COLS;
            in_win = col >= WIN_COL_LO && col <= WIN_COL_HI && row >= WIN_ROW_LO &&
                     row <= WIN_ROW_HI;
            r      = rand32();
            box    = rand32();
            case (mode)
                MODE_BORDER: conf = in_win ? r[7:0] : 8'hff;
                MODE_EQUAL:  conf = 8'h5a;
                // only four window cells carry a score
                MODE_SPARSE: conf = (col == 3 * row) ? (r[7:0] | 8'h01) : 8'h00;
                default:     conf = r[7:0];
            endcase
            beat_mem[i] = {r[31:8], conf, box};
            if (in_win) rank_insert(conf, box, col_t'(col), row_t'(row));
        end
    endtask

    task automatic run_case(input int t);
        logic        gap_en;
        logic        probe;
        logic        fire;
        logic [31:0] r;
        word_t       exp;
        int          idx;
        int          n;
        gap_en    = CASE_TAB[t][1];
        probe     = CASE_TAB[t][0];
        test_errs = 0;
        build_frame(int'(CASE_TAB[t][3:2]));
        i_start = 1'b1;
        @(posedge clk);
        #2;
        i_start = 1'b0;
        idx = 0;
        while (idx < NUM_BEATS) begin
            r = rand32();
            i_valid = !(gap_en && r[3:2] == 2'b00);
            // junk with full confidence on idle cycles
            i_beat = i_valid ? beat_mem[idx] : {32'hffff_ffff, r};
            check_val("o_ready", o_ready, 1);
            fire = i_valid && o_ready;
            @(posedge clk);
            #2;
            if (fire) idx++;
        end
        i_valid = 1'b0;
        check_val("o_ready", o_ready, 0);
        check_val("o_done", o_done, 0);
        // count edges from the last-beat edge until done shows
        n = 1;
        while (!o_done && n < 8) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!o_done) begin
            $display("o_done never rose after the last beat was accepted");
            errors++;
            test_errs++;
        end else begin
            check_val("done_latency", n, 2);
        end
        if (probe) begin
            i_start = 1'b1;
            @(posedge clk);
            #2;
            i_start = 1'b0;
            @(posedge clk);
            #2;
            check_val("o_ready", o_ready, 0);
            check_val("o_done", o_done, 1);
        end
        for (int a = 0; a < 16; a++) begin
            i_rd_addr = rd_addr_t'(a);
            if (a >= RESULT_WORDS) exp = '0;
            else if (a % 2 == 0) exp = exp_box[a/2];
            else exp = {exp_conf[a/2], exp_col[a/2], exp_row[a/2], 16'h0000};
            @(posedge clk);
            #2;
            check_val($sformatf("o_rd_data[%0d]", a), o_rd_data, exp);
        end
        check_val("o_done", o_done, 1);
        i_clr = 1'b1;
        @(posedge clk);
        #2;
        i_clr = 1'b0;
        check_val("o_done", o_done, 0);
        check_val("o_ready", o_ready, 0);
        $display("test %0d (mode %0d gap %0d probe %0d): %s", t, CASE_TAB[t][3:2], gap_en,
                 probe, (test_errs == 0) ? "ok" : "FAILED");
        if (test_errs != 0) failed_tests++;
    endtask

    initial begin
        clk          = 1'b0;
        e203_rst_n   = 1'b0;
        i_start      = 1'b0;
        i_clr        = 1'b0;
        i_valid      = 1'b0;
        i_beat       = '0;
        i_rd_addr    = '0;
        rng          = 32'h7151_32e6;
        errors       = 0;
        failed_tests = 0;
        repeat (5) @(posedge clk);
        #2;
        e203_rst_n = 1'b1;
        check_val("o_ready", o_ready, 0);
        check_val("o_done", o_done, 0);
        check_val("o_rd_data", o_rd_data, 0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_case(t);
        end
        $display("tests %0d, failing %0d, errors %0d", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
rtl/yolo_pkg.sv
rtl/grid_scanner.sv
rtl/top5_sorter.sv
rtl/result_store.sv
rtl/yolo_layer_top.sv
test/tb_yolo_layer.sv

/* Bender.yml */
package:
  name: yolo_layer

sources:
  - rtl/yolo_pkg.sv
  - rtl/grid_scanner.sv
  - rtl/top5_sorter.sv
  - rtl/result_store.sv
  - rtl/yolo_layer_top.sv
  - target: test
    files:
      - test/tb_yolo_layer.sv
